// File: Makefile
VERILATOR  ?= verilator
TOP        ?= tb_laser
FILELIST   ?= project.f
OBJ_DIR    ?= obj_dir
TIMESCALE  ?= 1ns/1ps
VFLAGS     ?= --timing --timescale $(TIMESCALE)
LINT_FLAGS ?= -Wall
PASS_MSG   ?= sim passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	@out="$$($(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: hdl/bus_sequencer.sv
module bus_sequencer
	import laser_pkg::*;
(
	input  logic  BASE_CLK,
	input  logic  RESET_N,
	input  logic  wb_cyc,
	input  logic  wb_stb,
	input  logic  wb_we,
	input  addr_t wb_adr,
	input  data_t wb_dat_w,
	output data_t wb_dat_r,
	output logic  wb_ack,
	mem_bus_if.seq bus,
	output data_t row_sel,
	input  data_t key_col,
	output data_t ctl_latch
);

	phase_cnt_t phase_cnt;
	phase_t     phase;
	logic       take;      // Access accepted this clock
	logic       acc_valid; // Access in flight, phases 1 and 2
	logic       acc_we;
	logic       acc_io;    // 6800-6FFF, handled here
	addr_t      acc_addr;
	data_t      acc_wdata;
	data_t      key_latch; // Column byte for I/O reads
	logic       ack_r;

	always_comb
		case (phase_cnt)
			4'd0:    phase = PH_SETUP;
			4'd1:    phase = PH_LATCH;
			4'd2:    phase = PH_DONE;
			default: phase = PH_IDLE;
		endcase

	// Late requests wait for the next phase 0
	assign take = wb_cyc && wb_stb && (phase == PH_SETUP);

	always_ff @(posedge BASE_CLK or negedge RESET_N)
		if (!RESET_N)
		begin
			phase_cnt <= '0;
			acc_valid <= 1'b0;
			ack_r     <= 1'b0;
			ctl_latch <= '0;
		end
		else
		begin
			if (phase_cnt == BUS_PHASES - 1'b1)
				phase_cnt <= '0;
			else
				phase_cnt <= phase_cnt + 1'b1;
			ack_r <= (phase == PH_LATCH) && acc_valid; // High during PH_DONE only
			if (phase == PH_SETUP)
				acc_valid <= take;
			else if (phase == PH_DONE)
				acc_valid <= 1'b0;
			if ((phase == PH_LATCH) && acc_valid && acc_io && acc_we)
				ctl_latch <= acc_wdata; // 74LS174 latch load
		end

	always_ff @(posedge BASE_CLK)
	begin
		if (take)
		begin
			acc_addr  <= wb_adr;
			acc_wdata <= wb_dat_w;
			acc_we    <= wb_we;
			acc_io    <= (wb_adr[15:11] == IO_PREFIX);
		end
		if ((phase == PH_LATCH) && acc_valid && acc_io && !acc_we)
			key_latch <= key_col; // Row lines settled since phase 1
	end

	assign bus.addr      = acc_addr;
	assign bus.wdata     = acc_wdata;
	assign bus.wr_strobe = (phase == PH_LATCH) && acc_valid && acc_we && !acc_io;

	assign row_sel  = acc_addr[7:0]; // Active-low row select
	assign wb_ack   = ack_r;
	assign wb_dat_r = acc_io ? key_latch : bus.rdata;

endmodule

// File: hdl/frame_irq.sv
module frame_irq
	import laser_pkg::*;
(
	input  logic BASE_CLK,
	input  logic RESET_N,
	output logic irq
);

	int_cnt_t cnt; // Position within the frame

	always_ff @(posedge BASE_CLK or negedge RESET_N)
		if (!RESET_N)
		begin
			cnt <= '0;
			irq <= 1'b0;
		end
		else
		begin
			if (cnt == INT_PERIOD - 1'b1)
				cnt <= '0; // Frame wrap
			else
				cnt <= cnt + 1'b1;
			irq <= (cnt < INT_HIGH); // First INT_HIGH clocks of each frame
		end

endmodule

// File: hdl/kbd_matrix.sv
module kbd_matrix
	import laser_pkg::*;
(
	input  logic  BASE_CLK,
	input  logic  RESET_N,
	input  logic  scan_valid,
	input  scan_t scan_code,
	input  logic  scan_pressed,
	input  logic  scan_extended,
	input  logic  cass_in,
	input  data_t row_sel,     // Bit r low selects row r
	output data_t key_col,
	output logic  key_pressed
);

	key_vec_t   key;     // Row r in bits 8r+5..8r
	key_ex_t    key_ex;
	key_vec_t   km;      // Matrix with extended keys merged in
	logic [5:0] col;
	int         slot;

	// Matrix index, KEY_COUNT plus extended index, or -1
	function automatic int key_slot(scan_t code, logic ext);
		int s;
		s = -1;
		case (code)
			8'h2C: s = 0;  // T
			8'h1D: s = 1;  // W
			8'h24: s = 3;  // E
			8'h15: s = 4;  // Q
			8'h2D: s = 5;  // R
			8'h34: s = 8;  // G
			8'h1B: s = 9;  // S
			8'h14: s = 10; // Ctrl
			8'h23: s = 11; // D
			8'h1C: s = 12; // A
			8'h2B: s = 13; // F
			8'h32: s = 16; // B
			8'h22: s = 17; // X
			8'h12: s = 18; // L-shift
			8'h21: s = 19; // C
			8'h1A: s = 20; // Z
			8'h2A: s = 21; // V
			8'h2E: s = 24; // 5
			8'h1E: s = 25; // 2
			8'h26: s = 27; // 3
			8'h16: s = 28; // 1
			8'h25: s = 29; // 4
			8'h31: s = 32; // N
			8'h49: s = 33; // .
			8'h41: s = 35; // ,
			8'h29: s = 36; // Space
			8'h3A: s = 37; // M
			8'h36: s = 40; // 6
			8'h46: s = 41; // 9
			8'h4E: s = 42; // -
			8'h3E: s = 43; // 8
			8'h45: s = 44; // 0
			8'h3D: s = 45; // 7
			8'h35: s = 48; // Y
			8'h44: s = 49; // O
			8'h5A: s = 50; // Return
			8'h43: s = 51; // I
			8'h4D: s = 52; // P
			8'h3C: s = 53; // U
			8'h33: s = 56; // H
			8'h4B: s = 57; // L
			8'h52: s = 58; // Quote key, used as colon
			8'h42: s = 59; // K
			8'h4C: s = 60; // ;
			8'h3B: s = 61; // J
			8'h59: s = KEY_COUNT + EX_RSHIFT;
			8'h11: s = ext ? KEY_COUNT + EX_RALT : KEY_COUNT + EX_LALT;
			8'h76: s = KEY_COUNT + EX_ESC;
			8'h75: s = KEY_COUNT + EX_UP;
			8'h6B: s = KEY_COUNT + EX_LEFT;
			8'h74: s = KEY_COUNT + EX_RIGHT;
			8'h72: s = KEY_COUNT + EX_DOWN;
			8'h66: s = KEY_COUNT + EX_BKSP;
			default: s = -1; // Unmapped code
		endcase
		return s;
	endfunction

	assign slot = key_slot(scan_code, scan_extended);

	always_ff @(posedge BASE_CLK or negedge RESET_N)
		if (!RESET_N)
		begin
			key    <= '1; // All released
			key_ex <= '1;
		end
		else if (scan_valid)
		begin
			if (slot >= KEY_COUNT)
				key_ex[4'(slot - KEY_COUNT)] <= ~scan_pressed;
			else if (slot >= 0)
				key[6'(slot)] <= ~scan_pressed;
		end

	// Extended keys fold onto Ctrl chords
	always_comb
	begin
		km     = key;
		km[10] = key[10] & (&key_ex[EX_BKSP:EX_ESC]);               // Ctrl
		km[18] = key[18] & key_ex[EX_RSHIFT];                       // Shift
		km[33] = key[33] & key_ex[EX_UP];                           // Ctrl .
		km[35] = key[35] & key_ex[EX_RIGHT];                        // Ctrl ,
		km[36] = key[36] & key_ex[EX_DOWN];                         // Ctrl space
		km[37] = key[37] & key_ex[EX_LEFT] & key_ex[EX_BKSP];       // Ctrl M
		km[42] = key[42] & key_ex[EX_ESC];                          // Ctrl -
	end

	// A column reads low if any selected row has that key down
	always_comb
	begin
		col = '1;
		for (int r = 0; r < 8; r++)
			for (int k = 0; k < 6; k++)
				if (!row_sel[r] && !km[6'(8 * r + k)])
					col[k] = 1'b0;
	end

	assign key_col     = {1'b1, ~cass_in, col}; // Bit 7 idles high
	assign key_pressed = (km != '1);

endmodule

// File: hdl/laser_pkg.sv
package laser_pkg;

	typedef logic [15:0] addr_t;      // Host bus address
	typedef logic [7:0]  data_t;      // Host bus data
	typedef logic [13:0] ram_addr_t;  // 16 KB main RAM word index
	typedef logic [10:0] vram_addr_t; // 2 KB video RAM word index
	typedef logic [7:0]  scan_t;      // PS/2 scan code
	typedef logic [3:0]  phase_cnt_t; // Free-running phase count

	// Bus cycle phases
	typedef enum logic [1:0] {
		PH_SETUP,  // Phase 0, access taken
		PH_LATCH,  // Phase 1, write and latch
		PH_DONE,   // Phase 2, ack with data
		PH_IDLE    // Phases 3 to 13
	} phase_t;

	localparam phase_cnt_t BUS_PHASES = 4'd14; // Clocks per bus cycle
	localparam data_t      OPEN_BUS   = 8'hFF;

	// Decode on address bits 15..11
	localparam logic [4:0] IO_PREFIX    = 5'b01101; // 6800-6FFF
	localparam logic [4:0] VRAM_PREFIX  = 5'b01110; // 7000-77FF
	localparam logic [4:0] RAM78_PREFIX = 5'b01111; // 7800-7FFF
	localparam logic [4:0] RAMB0_PREFIX = 5'b10110; // B000-B7FF
	// Decode on the top nibble, 8000-AFFF
	localparam logic [3:0] RAM_HI_FIRST = 4'h8;
	localparam logic [3:0] RAM_HI_LAST  = 4'hA;

	// Key matrix, 0 means pressed
	localparam int KEY_COUNT    = 64;
	localparam int KEY_EX_COUNT = 9;
	typedef logic [KEY_COUNT-1:0]    key_vec_t;
	typedef logic [KEY_EX_COUNT-1:0] key_ex_t;

	// Extended key positions
	localparam int EX_RSHIFT = 0;
	localparam int EX_LALT   = 1;
	localparam int EX_RALT   = 2;
	localparam int EX_ESC    = 3;
	localparam int EX_UP     = 4;
	localparam int EX_LEFT   = 5;
	localparam int EX_RIGHT  = 6;
	localparam int EX_DOWN   = 7;
	localparam int EX_BKSP   = 8;

	// Frame interrupt timing in BASE_CLK cycles
	typedef logic [17:0] int_cnt_t;
	localparam int_cnt_t INT_PERIOD = 18'd200000;
	localparam int_cnt_t INT_HIGH   = 18'd640;

	// Control latch bits
	localparam int CTL_SPK_A = 0;
	localparam int CTL_CASS  = 2;
	localparam int CTL_AG    = 3;
	localparam int CTL_CSS   = 4;
	localparam int CTL_SPK_B = 5;

endpackage

// File: hdl/laser_top.sv
module laser_top
	import laser_pkg::*;
(
	input  logic  BASE_CLK,
	input  logic  RESET_N,
	// Wishbone classic slave, stands in for the CPU
	input  logic  wb_cyc,
	input  logic  wb_stb,
	input  logic  wb_we,
	input  addr_t wb_adr,
	input  data_t wb_dat_w,
	output data_t wb_dat_r,
	output logic  wb_ack,
	// Decoded PS/2 events
	input  logic  scan_valid,
	input  scan_t scan_code,
	input  logic  scan_pressed,
	input  logic  scan_extended,
	input  logic  cass_in,       // Tape input level
	output logic  speaker_a,
	output logic  speaker_b,
	output logic  cass_out,
	output logic  vdg_ag,        // Alpha/graphics mode
	output logic  vdg_css,       // Color set select
	output logic  key_pressed,
	output logic  irq            // Frame interrupt
);

	data_t row_sel;   // Low address byte of an I/O read
	data_t key_col;
	data_t ctl_latch;

	mem_bus_if u_bus ();

	bus_sequencer u_bus_sequencer (
		.BASE_CLK  (BASE_CLK),
		.RESET_N   (RESET_N),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_dat_w  (wb_dat_w),
		.wb_dat_r  (wb_dat_r),
		.wb_ack    (wb_ack),
		.bus       (u_bus.seq),
		.row_sel   (row_sel),
		.key_col   (key_col),
		.ctl_latch (ctl_latch)
	);

	mem_map u_mem_map (
		.BASE_CLK (BASE_CLK),
		.bus      (u_bus.mem)
	);

	kbd_matrix u_kbd_matrix (
		.BASE_CLK      (BASE_CLK),
		.RESET_N       (RESET_N),
		.scan_valid    (scan_valid),
		.scan_code     (scan_code),
		.scan_pressed  (scan_pressed),
		.scan_extended (scan_extended),
		.cass_in       (cass_in),
		.row_sel       (row_sel),
		.key_col       (key_col),
		.key_pressed   (key_pressed)
	);

	frame_irq u_frame_irq (
		.BASE_CLK (BASE_CLK),
		.RESET_N  (RESET_N),
		.irq      (irq)
	);

	// Control latch fan-out
	assign speaker_a = ctl_latch[CTL_SPK_A];
	assign speaker_b = ctl_latch[CTL_SPK_B];
	assign cass_out  = ctl_latch[CTL_CASS];
	assign vdg_ag    = ctl_latch[CTL_AG];
	assign vdg_css   = ctl_latch[CTL_CSS];

endmodule

// File: hdl/mem_bus_if.sv
interface mem_bus_if
	import laser_pkg::*;
();

	addr_t addr;      // Held from PH_SETUP through PH_DONE
	data_t wdata;
	logic  wr_strobe; // One clock, at PH_LATCH
	data_t rdata;     // Valid from PH_DONE

	// Sequencer side
	modport seq (
		output addr,
		output wdata,
		output wr_strobe,
		input  rdata
	);

	// Memory map side
	modport mem (
		input  addr,
		input  wdata,
		input  wr_strobe,
		output rdata
	);

endinterface

// File: hdl/mem_map.sv
module mem_map
	import laser_pkg::*;
(
	input  logic   BASE_CLK,
	mem_bus_if.mem bus
);

	logic       is_vram;
	logic       is_ram;
	logic       vram_we;
	logic       ram_we;
	logic       vram_q;  // Region of the data now on the RAM outputs
	logic       ram_q;
	vram_addr_t vram_idx;
	ram_addr_t  ram_idx;
	data_t      vram_rd;
	data_t      ram_rd;

	assign is_vram = (bus.addr[15:11] == VRAM_PREFIX);
	// 7800-7FFF and 8000-B7FF as one 16 KB block
	assign is_ram  = (bus.addr[15:11] == RAM78_PREFIX) ||
	                 (bus.addr[15:11] == RAMB0_PREFIX) ||
	                 ((bus.addr[15:12] >= RAM_HI_FIRST) && (bus.addr[15:12] <= RAM_HI_LAST));

	assign vram_idx = bus.addr[10:0];
	assign ram_idx  = bus.addr[13:0]; // 7800 lands at 3800, 8000 at 0000

	assign vram_we = bus.wr_strobe && is_vram;
	assign ram_we  = bus.wr_strobe && is_ram;

	always_ff @(posedge BASE_CLK)
	begin
		vram_q <= is_vram; // Follows the RAM read latency
		ram_q  <= is_ram;
	end

	sys_ram #(.ADDR_W(11)) u_vram (
		.BASE_CLK (BASE_CLK),
		.addr     (vram_idx),
		.we       (vram_we),
		.wdata    (bus.wdata),
		.rdata    (vram_rd)
	);

	sys_ram #(.ADDR_W(14)) u_main_ram (
		.BASE_CLK (BASE_CLK),
		.addr     (ram_idx),
		.we       (ram_we),
		.wdata    (bus.wdata),
		.rdata    (ram_rd)
	);

	// ROM, I/O and holes float high
	assign bus.rdata = vram_q ? vram_rd : (ram_q ? ram_rd : OPEN_BUS);

endmodule

// File: hdl/sys_ram.sv
module sys_ram
	import laser_pkg::*;
#(
	parameter int ADDR_W = 11
)
(
	input  logic              BASE_CLK,
	input  logic [ADDR_W-1:0] addr,
	input  logic              we,
	input  data_t             wdata,
	output data_t             rdata
);

	data_t mem [2**ADDR_W];

	always_ff @(posedge BASE_CLK)
	begin
		if (we)
			mem[addr] <= wdata;
		rdata <= mem[addr]; // Old data on a write cycle
	end

endmodule

// File: project.f
hdl/laser_pkg.sv
hdl/mem_bus_if.sv
hdl/sys_ram.sv
hdl/mem_map.sv
hdl/kbd_matrix.sv
hdl/frame_irq.sv
hdl/bus_sequencer.sv
hdl/laser_top.sv
verif/laser_sva.sv
verif/tb_laser.sv

// File: verif/laser_sva.sv
module laser_sva
	import laser_pkg::*;
(
	input logic BASE_CLK,
	input logic RESET_N,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_ack,
	input logic irq
);
	timeunit 1ns;
	timeprecision 1ps;

	int_cnt_t hi_cnt; // Clocks irq has been high so far

	always_ff @(posedge BASE_CLK or negedge RESET_N)
		if (!RESET_N)
			hi_cnt <= '0;
		else if (irq)
			hi_cnt <= hi_cnt + 1'b1;
		else
			hi_cnt <= '0;

	ack_one_cycle: assert property (@(posedge BASE_CLK) disable iff (!RESET_N)
		wb_ack |=> !wb_ack)
		else $error("wb_ack high for more than one cycle");

	ack_in_cycle: assert property (@(posedge BASE_CLK) disable iff (!RESET_N)
		wb_ack |-> (wb_cyc && wb_stb))
		else $error("wb_ack without wb_cyc and wb_stb");

	// Full pulse counted when irq falls
	irq_width: assert property (@(posedge BASE_CLK) disable iff (!RESET_N)
		$fell(irq) |-> (hi_cnt == INT_HIGH))
		else $error("irq pulse width differs from INT_HIGH");

endmodule

bind bus_sequencer laser_sva u_bus_sva (
	.BASE_CLK (BASE_CLK),
	.RESET_N  (RESET_N),
	.wb_cyc   (wb_cyc),
	.wb_stb   (wb_stb),
	.wb_ack   (wb_ack),
	.irq      (1'b0)
);

bind frame_irq laser_sva u_irq_sva (
	.BASE_CLK (BASE_CLK),
	.RESET_N  (RESET_N),
	.wb_cyc   (1'b0),
	.wb_stb   (1'b0),
	.wb_ack   (1'b0),
	.irq      (irq)
);

// File: verif/tb_laser.sv
module tb_laser
	import laser_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [31:0] SEED       = 32'h38ad1238;
	localparam int          BUS_BUDGET = 50000;                        // Bus tests need a few thousand
	localparam int          TIMEOUT_CYCLES = 2 * INT_PERIOD + BUS_BUDGET; // Two frames plus bus tests
	localparam int          RAM_N   = 6;
	localparam int          OPEN_N  = 4;
	localparam int          ALIAS_N = 3;
	localparam int          CTL_N   = 7;
	localparam int          KBD_N   = 10;

	// Scan event then a column read
	typedef struct packed {
		scan_t code;
		logic  ext;
		logic  pressed;
		logic  cass;
		addr_t adr;
		data_t exp;     // Bit 7 high, bit 6 ~cass, low bits per column
		logic  kp;      // Expected key_pressed
	} kbd_step_t;

	logic  BASE_CLK, RESET_N;
	logic  wb_cyc, wb_stb, wb_we, wb_ack;
	addr_t wb_adr;
	data_t wb_dat_w, wb_dat_r;
	logic  scan_valid, scan_pressed, scan_extended, cass_in;
	scan_t scan_code;
	logic  speaker_a, speaker_b, cass_out, vdg_ag, vdg_css, key_pressed, irq;

	int unsigned cycles = 0;
	int unsigned rise_at[$];     // Cycle of each irq rising edge
	int unsigned width_q[$];     // Length of each irq pulse
	int unsigned hi_run = 0;
	logic        irq_prev = 1'b0;

	addr_t ram_adr [RAM_N] = '{16'h7000, 16'h77FF, 16'h7800, 16'h8000, 16'hA123, 16'hB7FF};
	data_t ram_dat [RAM_N];      // Random fill
	addr_t open_adr [OPEN_N] = '{16'h0000, 16'h3FFF, 16'hB800, 16'hC000};
	addr_t vram_alias [ALIAS_N] = '{16'h7123, 16'h7456, 16'h7700};
	addr_t ram_alias [ALIAS_N]  = '{16'h8123, 16'hB456, 16'h8700}; // Same low bits
	addr_t ctl_adr [CTL_N] = '{16'h6800, 16'h6FFF, 16'h6800, 16'h6FFF, 16'h6800, 16'h6FFF, 16'h6800};
	data_t ctl_dat [CTL_N] = '{8'h01, 8'h20, 8'h04, 8'h08, 8'h10, 8'hFF, 8'h00};

	// T r0c0, A r1c4, H r7c0, left arrow as Ctrl M (r1c2 and r4c5), code 00 is a no-op
	kbd_step_t kbd_tab [KBD_N] = '{
		'{8'h2C, 1'b0, 1'b1, 1'b0, 16'h68FE, 8'hFE, 1'b1},
		'{8'h1C, 1'b0, 1'b1, 1'b0, 16'h68FD, 8'hEF, 1'b1},
		'{8'h33, 1'b0, 1'b1, 1'b1, 16'h687F, 8'hBE, 1'b1},
		'{8'h6B, 1'b1, 1'b1, 1'b0, 16'h68EF, 8'hDF, 1'b1},
		'{8'h00, 1'b0, 1'b0, 1'b0, 16'h68FD, 8'hEB, 1'b1},
		'{8'h00, 1'b0, 1'b0, 1'b0, 16'h6800, 8'hCA, 1'b1},
		'{8'h2C, 1'b0, 1'b0, 1'b0, 16'h68FE, 8'hFF, 1'b1},
		'{8'h6B, 1'b1, 1'b0, 1'b1, 16'h6800, 8'hAE, 1'b1},
		'{8'h1C, 1'b0, 1'b0, 1'b0, 16'h68FD, 8'hFF, 1'b1},
		'{8'h33, 1'b0, 1'b0, 1'b0, 16'h6800, 8'hFF, 1'b0}
	};

	laser_top u_laser_top (.*);

	initial
	begin
		BASE_CLK = 1'b0;
		forever #4 BASE_CLK = ~BASE_CLK; // 8 ns period
	end

	always @(posedge BASE_CLK)
	begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT_CYCLES)
		begin
			$display("Timeout: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
			$display("sim failed");
			$fatal(1, "Timeout");
		end
	end

	// irq pulse monitor from reset release
	always @(negedge BASE_CLK)
		if (RESET_N)
		begin
			if (irq && !irq_prev)
				rise_at.push_back(cycles);
			if (irq)
				hi_run++;
			else if (irq_prev)
			begin
				width_q.push_back(hi_run); // Pulse ended
				hi_run = 0;
			end
			irq_prev = irq;
		end

	task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("** Error at %0t ns: %s gave %0h, expected %0h", $time, what, got, exp);
			$display("sim failed");
			$fatal(1, "Check failed");
		end
	endtask

	// One Wishbone classic access waiting for ack
	task automatic wb_cycle(input logic we, input addr_t adr, input data_t wdat,
	                        output data_t rdat);
		@(negedge BASE_CLK);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = wdat;
		do
			@(negedge BASE_CLK);
		while (!wb_ack);
		rdat = wb_dat_r;      // Valid in the ack cycle
		@(negedge BASE_CLK);  // stb held through ack
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic write_byte(input addr_t adr, input data_t dat);
		data_t unused;
		wb_cycle(1'b1, adr, dat, unused);
	endtask

	task automatic read_byte(input addr_t adr, output data_t dat);
		wb_cycle(1'b0, adr, 8'h00, dat);
	endtask

	task automatic send_scan(input scan_t code, input logic ext, input logic pressed);
		@(negedge BASE_CLK);
		scan_valid    = 1'b1;
		scan_code     = code;
		scan_extended = ext;
		scan_pressed  = pressed;
		@(negedge BASE_CLK);
		scan_valid = 1'b0;
	endtask

	initial
	begin
		data_t rd;
		data_t a_dat;
		RESET_N       = 1'b0;
		wb_cyc        = 1'b0;
		wb_stb        = 1'b0;
		wb_we         = 1'b0;
		wb_adr        = '0;
		wb_dat_w      = '0;
		scan_valid    = 1'b0;
		scan_code     = '0;
		scan_pressed  = 1'b0;
		scan_extended = 1'b0;
		cass_in       = 1'b0;
		void'($urandom(SEED)); // Seed once
		repeat (3) @(posedge BASE_CLK);
		@(negedge BASE_CLK);
		RESET_N = 1'b1;
		@(negedge BASE_CLK);

		// Reset state
		check_val("speaker_a after reset", speaker_a, 0);
		check_val("speaker_b after reset", speaker_b, 0);
		check_val("cass_out after reset", cass_out, 0);
		check_val("vdg_ag after reset", vdg_ag, 0);
		check_val("vdg_css after reset", vdg_css, 0);
		check_val("key_pressed after reset", key_pressed, 0);
		check_val("wb_ack after reset", wb_ack, 0);

		// RAM round trip
		foreach (ram_adr[i])
		begin
			ram_dat[i] = 8'($urandom);
			write_byte(ram_adr[i], ram_dat[i]);
		end
		foreach (ram_adr[i])
		begin
			read_byte(ram_adr[i], rd);
			check_val($sformatf("RAM read %h", ram_adr[i]), rd, ram_dat[i]);
		end

		// Writes to open bus land nowhere
		foreach (open_adr[i])
		begin
			read_byte(open_adr[i], rd);
			check_val($sformatf("open bus %h", open_adr[i]), rd, OPEN_BUS);
			write_byte(open_adr[i], 8'($urandom) & 8'h7F);
			read_byte(open_adr[i], rd);
			check_val($sformatf("open bus after write %h", open_adr[i]), rd, OPEN_BUS);
		end
		foreach (ram_adr[i])
		begin
			read_byte(ram_adr[i], rd);
			check_val($sformatf("RAM kept %h", ram_adr[i]), rd, ram_dat[i]);
		end

		// VRAM and main RAM stay apart
		foreach (vram_alias[i])
		begin
			a_dat = 8'($urandom);
			write_byte(vram_alias[i], a_dat);
			write_byte(ram_alias[i], ~a_dat);
			read_byte(vram_alias[i], rd);
			check_val($sformatf("VRAM %h", vram_alias[i]), rd, a_dat);
			write_byte(vram_alias[i], a_dat); // Must not reach main RAM
			read_byte(ram_alias[i], rd);
			check_val($sformatf("main RAM %h", ram_alias[i]), rd, data_t'(~a_dat));
		end

		// Control latch fan-out
		for (int i = 0; i < CTL_N; i++)
		begin
			write_byte(ctl_adr[i], ctl_dat[i]);
			check_val("speaker_a", speaker_a, ctl_dat[i][CTL_SPK_A]);
			check_val("speaker_b", speaker_b, ctl_dat[i][CTL_SPK_B]);
			check_val("cass_out", cass_out, ctl_dat[i][CTL_CASS]);
			check_val("vdg_ag", vdg_ag, ctl_dat[i][CTL_AG]);
			check_val("vdg_css", vdg_css, ctl_dat[i][CTL_CSS]);
		end

		// Keyboard matrix
		for (int i = 0; i < KBD_N; i++)
		begin
			send_scan(kbd_tab[i].code, kbd_tab[i].ext, kbd_tab[i].pressed);
			cass_in = kbd_tab[i].cass;
			read_byte(kbd_tab[i].adr, rd);
			check_val($sformatf("key column %h", kbd_tab[i].adr), rd, kbd_tab[i].exp);
			check_val($sformatf("key_pressed step %0d", i), key_pressed, kbd_tab[i].kp);
		end
		cass_in = 1'b0;

		// Three irq pulses span two periods
		while (width_q.size() < 3)
			@(negedge BASE_CLK);
		for (int i = 0; i < 3; i++)
			check_val($sformatf("irq width %0d", i), width_q[i], INT_HIGH);
		for (int i = 1; i < 3; i++)
			check_val($sformatf("irq period %0d", i), rise_at[i] - rise_at[i-1], INT_PERIOD);

		$display("sim passed");
		$finish;
	end

endmodule
